// File: bus_config_regs.sv
`timescale 1ns/1ps
module bus_config_regs
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cfg_we,
    input  logic [3:0] cfg_dev_code,
    input  logic       cfg_wp,
    output logic [3:0] dev_code,
    output logic       wp
);
    import eeprom_pkg::*;

    // both fields load together from one configuration command
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            dev_code <= DEV_CODE_RESET;
            wp       <= 1'b0;  // writes allowed after reset
        end
        else if (cfg_we)
        begin
            dev_code <= cfg_dev_code;
            wp       <= cfg_wp;
        end
    end

endmodule

// File: eeprom_pkg.sv
package eeprom_pkg;

    // host op codes
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_CFG   = 2'd2;

    localparam int ADDR_W = 11;  // 2 K bytes

    localparam logic [3:0] DEV_CODE_RESET = 4'b1010;

    // memory view of the host word
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
    } mem_word_t;

    // configuration view, same 19 bits
    typedef struct packed {
        logic [13:0] unused;
        logic [3:0]  dev_code;
        logic        wp;
    } cfg_word_t;

    // decoded by op, mem for read/write and cfg for OP_CFG
    typedef union packed {
        mem_word_t mem;
        cfg_word_t cfg;
    } host_word_t;

endpackage

// File: eeprom_slave_model.sv
`timescale 1ns/1ps
module eeprom_slave_model
(
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);
    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam logic [2:0] P_IDLE = 3'd0;
    localparam logic [2:0] P_CTRL = 3'd1;
    localparam logic [2:0] P_ADDR = 3'd2;
    localparam logic [2:0] P_DATA = 3'd3;
    localparam logic [2:0] P_READ = 3'd4;

    logic [7:0]  mem [0:2047];
    logic [2:0]  phase = P_IDLE;
    logic [2:0]  next_phase = P_IDLE;
    logic [3:0]  bit_cnt = 4'd0;
    logic [7:0]  shreg = 8'h00;
    logic [7:0]  out_byte = 8'h00;
    logic [10:0] addr = 11'd0;
    logic        ack_now = 1'b0;  // pull sda low in the coming ninth clock
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;

    initial
    begin
        sda_drive_low = 1'b0;
        // low byte mixed with the block number
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {5'd0, 3'(i >> 8)} ^ 8'hc3;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            phase   = P_CTRL;  // start or repeated start
            bit_cnt = 4'd0;
            ack_now = 1'b0;
        end
        else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            phase         = P_IDLE;  // stop
            bit_cnt       = 4'd0;
            ack_now       = 1'b0;
            sda_drive_low = 1'b0;
        end
        else if (scl_q === 1'b0 && scl === 1'b1)
        begin
            if (phase == P_CTRL || phase == P_ADDR || phase == P_DATA)
            begin
                if (bit_cnt < 4'd8)
                begin
                    shreg   = {shreg[6:0], sda};
                    bit_cnt = bit_cnt + 4'd1;
                end
                else
                begin
                    bit_cnt = 4'd0;  // ack clock over
                    ack_now = 1'b0;
                    phase   = next_phase;
                end
                if (bit_cnt == 4'd8)
                begin
                    ack_now = 1'b1;
                    case (phase)
                        P_CTRL:
                        begin
                            addr[10:8] = shreg[3:1];
                            out_byte   = mem[{shreg[3:1], addr[7:0]}];
                            next_phase = shreg[0] ? P_READ : P_ADDR;
                            if (shreg[7:4] != DEV_CODE)
                            begin
                                ack_now = 1'b0;  // not addressed, stay quiet
                                phase   = P_IDLE;
                                bit_cnt = 4'd0;
                            end
                        end
                        P_ADDR:
                        begin
                            addr[7:0]  = shreg;
                            next_phase = P_DATA;
                        end
                        default:
                        begin
                            mem[addr]  = shreg;  // no write cycle delay
                            next_phase = P_IDLE;
                        end
                    endcase
                end
            end
            else if (phase == P_READ)
            begin
                if (bit_cnt < 4'd8)
                    bit_cnt = bit_cnt + 4'd1;
                else
                begin
                    phase   = P_IDLE;  // single byte, master answers nack
                    bit_cnt = 4'd0;
                end
            end
        end
        else if (scl_q === 1'b1 && scl === 1'b0)
        begin
            if (ack_now)
                sda_drive_low = 1'b1;
            else if (phase == P_READ && bit_cnt < 4'd8)
            begin
                sda_drive_low = ~out_byte[7];
                out_byte      = {out_byte[6:0], 1'b0};
            end
            else
                sda_drive_low = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: eeprom_subsystem.sv
`timescale 1ns/1ps
module eeprom_subsystem
#(
    parameter int SCL_DIV = 4
)
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   req,
    input  logic [1:0]             op,
    input  eeprom_pkg::host_word_t word,
    input  logic                   sda_in,
    output logic                   ack,
    output logic [7:0]             rd_data,
    output logic                   nack,
    output logic                   scl,
    output logic                   sda_drive_low
);
    import eeprom_pkg::*;

    logic              start;
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              done;
    logic [7:0]        rdata;
    logic              master_nack;
    logic              bus_active;
    logic              scl_fall_mid;
    logic              scl_high_mid;
    logic              cfg_we;
    logic [3:0]        cfg_dev_code;
    logic              cfg_wp;
    logic [3:0]        dev_code;
    logic              wp;

    scl_timer #(.SCL_DIV(SCL_DIV)) u_timer (
        .CLK(CLK), .RESET(RESET), .run(bus_active),
        .scl(scl), .scl_fall_mid(scl_fall_mid), .scl_high_mid(scl_high_mid)
    );

    bus_config_regs u_cfg (
        .CLK(CLK), .RESET(RESET), .cfg_we(cfg_we), .cfg_dev_code(cfg_dev_code),
        .cfg_wp(cfg_wp), .dev_code(dev_code), .wp(wp)
    );

    host_request_port u_port (
        .CLK(CLK), .RESET(RESET), .req(req), .op(op), .word(word), .wp(wp),
        .done(done), .rdata(rdata), .master_nack(master_nack),
        .ack(ack), .rd_data(rd_data), .nack(nack), .start(start),
        .is_read(is_read), .addr(addr), .wdata(wdata), .cfg_we(cfg_we),
        .cfg_dev_code(cfg_dev_code), .cfg_wp(cfg_wp)
    );

    serial_eeprom_master u_master (
        .CLK(CLK), .RESET(RESET), .start(start), .is_read(is_read), .addr(addr),
        .wdata(wdata), .dev_code(dev_code), .scl(scl), .scl_fall_mid(scl_fall_mid),
        .scl_high_mid(scl_high_mid), .sda_in(sda_in), .done(done), .rdata(rdata),
        .nack(master_nack), .bus_active(bus_active), .sda_drive_low(sda_drive_low)
    );

endmodule

// File: files.f
eeprom_pkg.sv
scl_timer.sv
bus_config_regs.sv
host_request_port.sv
serial_eeprom_master.sv
eeprom_subsystem.sv
eeprom_slave_model.sv
tb_eeprom.sv

// File: host_request_port.sv
`timescale 1ns/1ps
module host_request_port
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req,
    input  logic [1:0]                    op,
    input  eeprom_pkg::host_word_t        word,
    input  logic                          wp,
    input  logic                          done,
    input  logic [7:0]                    rdata,
    input  logic                          master_nack,
    output logic                          ack,
    output logic [7:0]                    rd_data,
    output logic                          nack,
    output logic                          start,
    output logic                          is_read,
    output logic [eeprom_pkg::ADDR_W-1:0] addr,
    output logic [7:0]                    wdata,
    output logic                          cfg_we,
    output logic [3:0]                    cfg_dev_code,
    output logic                          cfg_wp
);
    import eeprom_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUSY = 2'd1;
    localparam logic [1:0] S_ACK  = 2'd2;
    localparam logic [1:0] S_WAIT = 2'd3;  // ack high until req drops

    logic [1:0] state;
    logic [1:0] op_q;
    host_word_t word_q;
    logic       local_q;
    logic       take_local;

    // config and protected writes never touch the bus
    assign take_local = !((op == OP_READ) || (op == OP_WRITE && !wp));

    assign ack          = (state == S_WAIT);
    assign is_read      = (op_q == OP_READ);
    assign addr         = word_q.mem.addr;
    assign wdata        = word_q.mem.data;
    assign cfg_dev_code = word_q.cfg.dev_code;
    assign cfg_wp       = word_q.cfg.wp;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            start   <= 1'b0;
            cfg_we  <= 1'b0;
            nack    <= 1'b0;
            local_q <= 1'b0;
        end
        else
        begin
            start  <= 1'b0;
            cfg_we <= 1'b0;
            case (state)
                S_IDLE:
                    if (req)
                    begin
                        op_q    <= op;
                        word_q  <= word;
                        local_q <= take_local;
                        start   <= !take_local;
                        state   <= S_BUSY;
                    end
                S_BUSY:
                    if (local_q)
                    begin
                        cfg_we  <= (op_q == OP_CFG);
                        nack    <= (op_q == OP_WRITE);  // refused by wp
                        rd_data <= 8'h00;
                        state   <= S_ACK;
                    end
                    else if (done)
                    begin
                        rd_data <= rdata;
                        nack    <= master_nack;
                        state   <= S_ACK;
                    end
                S_ACK:
                    state <= S_WAIT;
                default:
                    if (!req)
                        state <= S_IDLE;
            endcase
        end
    end

    // host must hold the command until it sees ack
    a_op_stable: assert property (@(posedge CLK) disable iff (RESET)
        (req && !ack && $past(req)) |-> $stable(op));

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_eeprom -f files.f -o sim_eeprom
./obj_dir/sim_eeprom | tee sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

// File: scl_timer.sv
`timescale 1ns/1ps
module scl_timer
#(
    parameter int SCL_DIV = 4
)
(
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic scl_fall_mid,
    output logic scl_high_mid
);
    localparam int CNT_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(SCL_DIV / 2);

    logic [CNT_W-1:0] cnt;  // position inside the half period

    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            cnt <= '0;
            scl <= 1'b1;  // bus rests with scl high
        end
        else if (cnt == CNT_LAST)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    assign scl_fall_mid = run && !scl && (cnt == CNT_MID);
    assign scl_high_mid = run && scl && (cnt == CNT_MID);

    // sda moves on a strobe edge, scl must not toggle on that same edge
    a_strobe_off_edge: assert property (@(posedge CLK) disable iff (RESET)
        (scl_fall_mid || scl_high_mid) |=> $stable(scl));

endmodule

// File: serial_eeprom_master.sv
`timescale 1ns/1ps
module serial_eeprom_master
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          start,
    input  logic                          is_read,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic [3:0]                    dev_code,
    input  logic                          scl,
    input  logic                          scl_fall_mid,
    input  logic                          scl_high_mid,
    input  logic                          sda_in,
    output logic                          done,
    output logic [7:0]                    rdata,
    output logic                          nack,
    output logic                          bus_active,
    output logic                          sda_drive_low
);
    import eeprom_pkg::*;

    localparam logic [3:0] S_IDLE   = 4'd0;
    localparam logic [3:0] S_START  = 4'd1;
    localparam logic [3:0] S_CTRL   = 4'd2;
    localparam logic [3:0] S_ADDR   = 4'd3;
    localparam logic [3:0] S_DATA   = 4'd4;
    localparam logic [3:0] S_RSTART = 4'd5;
    localparam logic [3:0] S_RCTRL  = 4'd6;
    localparam logic [3:0] S_RBYTE  = 4'd7;
    localparam logic [3:0] S_MNACK  = 4'd8;
    localparam logic [3:0] S_STOP   = 4'd9;

    logic [3:0] state;
    logic [7:0] shreg;    // out msb first, in at lsb
    logic [3:0] bit_cnt;  // 8 is the ack slot
    logic [7:0] ctrl_wr;
    logic [7:0] ctrl_rd;
    logic       sending;

    assign ctrl_wr = {dev_code, addr[ADDR_W-1:8], 1'b0};
    assign ctrl_rd = {dev_code, addr[ADDR_W-1:8], 1'b1};

    assign sending = (state == S_CTRL) || (state == S_ADDR) ||
                     (state == S_DATA) || (state == S_RCTRL);

    assign bus_active = (state != S_IDLE);
    assign rdata      = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= S_IDLE;
            bit_cnt       <= 4'd0;
            nack          <= 1'b0;
            done          <= 1'b0;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == S_IDLE)
            begin
                if (start)
                begin
                    nack  <= 1'b0;
                    state <= S_START;
                end
            end
            else if (state == S_START || state == S_RSTART)
            begin
                if (scl_fall_mid)
                    sda_drive_low <= 1'b0;  // line high before repeated start
                else if (scl_high_mid)
                begin
                    sda_drive_low <= 1'b1;  // sda falls while scl high
                    shreg         <= (state == S_START) ? ctrl_wr : ctrl_rd;
                    bit_cnt       <= 4'd0;
                    state         <= (state == S_START) ? S_CTRL : S_RCTRL;
                end
            end
            else if (sending)
            begin
                if (scl_fall_mid)
                begin
                    if (bit_cnt == 4'd8)
                        sda_drive_low <= 1'b0;  // release for slave ack
                    else
                    begin
                        sda_drive_low <= ~shreg[7];
                        shreg         <= {shreg[6:0], 1'b0};
                    end
                end
                else if (scl_high_mid)
                begin
                    if (bit_cnt != 4'd8)
                        bit_cnt <= bit_cnt + 4'd1;
                    else
                    begin
                        bit_cnt <= 4'd0;
                        if (sda_in)
                        begin
                            nack  <= 1'b1;  // no ack, skip the rest
                            state <= S_STOP;
                        end
                        else
                        begin
                            case (state)
                                S_CTRL:
                                begin
                                    shreg <= addr[7:0];
                                    state <= S_ADDR;
                                end
                                S_ADDR:
                                begin
                                    shreg <= wdata;
                                    state <= is_read ? S_RSTART : S_DATA;
                                end
                                S_RCTRL:
                                    state <= S_RBYTE;
                                default:
                                    state <= S_STOP;
                            endcase
                        end
                    end
                end
            end
            else if (state == S_RBYTE)
            begin
                if (scl_high_mid)
                begin
                    shreg <= {shreg[6:0], sda_in};
                    if (bit_cnt == 4'd7)
                    begin
                        bit_cnt <= 4'd0;
                        state   <= S_MNACK;
                    end
                    else
                        bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (state == S_MNACK)
            begin
                // sda stays released, single byte read ends with nack
                if (scl_high_mid)
                    state <= S_STOP;
            end
            else
            begin
                if (scl_fall_mid)
                    sda_drive_low <= 1'b1;
                else if (scl_high_mid)
                begin
                    sda_drive_low <= 1'b0;  // stop condition
                    done          <= 1'b1;
                    state         <= S_IDLE;
                end
            end
        end
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done);

    // sda only moves right after a strobe, stop and start included
    a_sda_on_strobe: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) |-> $past(scl_fall_mid || scl_high_mid));

    a_sda_at_scl: assert property (@(posedge CLK) disable iff (RESET)
        (done |-> scl));

endmodule

// File: tb_eeprom.sv
`timescale 1ns/1ps
module tb_eeprom;
    import eeprom_pkg::*;

    localparam int TIMEOUT = 3000;  // clk cycles per wait

    logic        CLK = 1'b0;
    logic        RESET;
    logic        req;
    logic [1:0]  op;
    host_word_t  word;
    logic        ack;
    logic [7:0]  rd_data;
    logic        nack;
    logic        scl;
    logic        sda_drive_low;
    logic        slave_sda_low;
    logic        sda_line;

    logic [7:0]  ref_mem [0:2047];
    logic [10:0] used_addr [0:15];
    logic [31:0] rng = 32'd99687;
    int          errors = 0;
    int          idle_errors = 0;
    int          checks = 0;
    int          scl_falls = 0;

    eeprom_subsystem #(.SCL_DIV(4)) dut0 (
        .CLK(CLK), .RESET(RESET), .req(req), .op(op), .word(word), .sda_in(sda_line),
        .ack(ack), .rd_data(rd_data), .nack(nack), .scl(scl), .sda_drive_low(sda_drive_low)
    );

    eeprom_slave_model slave0 (.scl(scl), .sda(sda_line), .sda_drive_low(slave_sda_low));

    // open drain, either side pulls low
    assign sda_line = (sda_drive_low === 1'b1 || slave_sda_low === 1'b1) ? 1'b0 : 1'b1;

    always #5 CLK = ~CLK;

    always @(negedge scl)
    begin
        scl_falls++;
    end

    // bus must be idle whenever ack is up
    always @(negedge CLK)
    begin
        if (!RESET && ack === 1'b1 && (scl !== 1'b1 || sda_drive_low !== 1'b0))
        begin
            idle_errors++;
            $display("Error at %0t: scl = %b, sda_drive_low = %b with ack high, expected 1 and 0",
                     $time, scl, sda_drive_low);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic host_word_t mem_word(input logic [10:0] a, input logic [7:0] d);
        host_word_t w;
        w.mem.addr = a;
        w.mem.data = d;
        return w;
    endfunction

    function automatic host_word_t cfg_word(input logic [3:0] code, input logic p);
        host_word_t w;
        w              = '0;
        w.cfg.dev_code = code;
        w.cfg.wp       = p;
        return w;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, idle bus errors: %0d", checks, errors, idle_errors);
        if (errors == 0 && idle_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] exp);
        errors++;
        $display("Error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
    endtask

    // full four-phase handshake, called 1 ns after a rising edge
    task automatic run_command(input logic [1:0] cmd_op, input host_word_t cmd_word,
                               output logic [7:0] got_data, output logic got_nack);
        int waited;
        op     = cmd_op;
        word   = cmd_word;
        req    = 1'b1;
        waited = 0;
        while (ack !== 1'b1 && waited < TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (ack !== 1'b1)
        begin
            errors++;
            $display("Timeout: ack never rose for command with op %0d", cmd_op);
            finish_run();
        end
        got_data = rd_data;
        got_nack = nack;
        repeat (2) @(posedge CLK);  // hold req, ack has to stay
        #1;
        checks++;
        if (ack !== 1'b1)
            value_error("ack", {7'd0, ack}, 8'h01);
        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (ack !== 1'b0)
        begin
            errors++;
            $display("Timeout: ack stayed high after req was released");
            finish_run();
        end
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d, input logic exp_nack);
        logic [7:0] got_data;
        logic       got_nack;
        run_command(OP_WRITE, mem_word(a, d), got_data, got_nack);
        checks++;
        if (got_nack !== exp_nack)
            value_error("nack", {7'd0, got_nack}, {7'd0, exp_nack});
        if (!exp_nack)
            ref_mem[a] = d;
    endtask

    task automatic read_check(input logic [10:0] a, input logic exp_nack);
        logic [7:0] got_data;
        logic       got_nack;
        run_command(OP_READ, mem_word(a, 8'h00), got_data, got_nack);
        checks++;
        if (got_nack !== exp_nack)
            value_error("nack", {7'd0, got_nack}, {7'd0, exp_nack});
        if (!exp_nack && got_data !== ref_mem[a])
            value_error("rd_data", got_data, ref_mem[a]);
    endtask

    task automatic set_config(input logic [3:0] code, input logic p);
        logic [7:0] got_data;
        logic       got_nack;
        run_command(OP_CFG, cfg_word(code, p), got_data, got_nack);
        checks++;
        if (got_nack !== 1'b0)
            value_error("nack", {7'd0, got_nack}, 8'h00);
    endtask

    task automatic test_reset_state();
        checks++;
        if (ack !== 1'b0)
            value_error("ack", {7'd0, ack}, 8'h00);
        if (nack !== 1'b0)
            value_error("nack", {7'd0, nack}, 8'h00);
        if (sda_drive_low !== 1'b0)
            value_error("sda_drive_low", {7'd0, sda_drive_low}, 8'h00);
        if (scl !== 1'b1)
            value_error("scl", {7'd0, scl}, 8'h01);
    endtask

    task automatic test_write_read();
        for (int i = 0; i < 16; i++)
        begin
            rng          = xorshift32(rng);
            used_addr[i] = rng[10:0];
            write_byte(rng[10:0], rng[23:16], 1'b0);
        end
        for (int i = 0; i < 16; i++)
            read_check(used_addr[i], 1'b0);
    endtask

    // same low byte in all eight blocks
    task automatic test_high_bits();
        logic [7:0] low;
        logic [7:0] tag;
        rng = xorshift32(rng);
        low = rng[7:0];
        tag = rng[15:8];
        for (int hi = 0; hi < 8; hi++)
            write_byte({3'(hi), low}, {3'(hi), tag[4:0]}, 1'b0);
        for (int hi = 0; hi < 8; hi++)
            read_check({3'(hi), low}, 1'b0);
    endtask

    task automatic test_write_protect();
        int falls_before;
        set_config(4'b1010, 1'b1);
        falls_before = scl_falls;
        write_byte(used_addr[0], ~ref_mem[used_addr[0]], 1'b1);
        checks++;
        if (scl_falls != falls_before)
        begin
            errors++;
            $display("Error at %0t: scl falling edges = %0d, expected %0d",
                     $time, scl_falls, falls_before);
        end
        set_config(4'b1010, 1'b0);
        read_check(used_addr[0], 1'b0);  // old byte survives
    endtask

    task automatic test_device_code();
        set_config(4'b1011, 1'b0);
        read_check(used_addr[1], 1'b1);
        write_byte(used_addr[1], ~ref_mem[used_addr[1]], 1'b1);
        set_config(4'b1010, 1'b0);
        read_check(used_addr[1], 1'b0);
        read_check(used_addr[2], 1'b0);
    endtask

    initial
    begin
        RESET = 1'b1;
        req   = 1'b0;
        op    = OP_WRITE;
        word  = '0;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        test_reset_state();
        test_write_read();
        test_high_bits();
        test_write_protect();
        test_device_code();
        finish_run();
    end

endmodule
